//--- list.f
+incdir+verilog
verilog/axi_mem_pkg.sv
verilog/mem_req_if.sv
verilog/axi_burst_addr_gen.sv
verilog/axi2mem.sv
verilog/sram_bank.sv
verilog/axi_mem_top.sv
test/tb_clk_gen.sv
test/tb_axi_mem.sv

//--- Makefile
# Verilator build and run of the AXI4 memory slave testbench
# pass or fail is decided from sim.log, the simulator exit code is not used

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module tb_axi_mem \
		-f list.f -o tb_axi_mem
	./obj_dir/tb_axi_mem | tee sim.log
	@if grep -q "Simulation PASSED" sim.log; then \
		echo "run passed"; \
	else \
		echo "run failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- test/tb_axi_mem.sv
/* directed tests of the AXI4 memory slave; bursts go in on the channel ports,
   read data and responses are compared against a reference memory */
`timescale 1ns/100ps
`default_nettype none
`include "axi_mem_params.svh"

module tb_axi_mem;

    localparam int         TIMEOUT     = 200;
    localparam logic [2:0] FULL_SIZE   = 3'(`LOG_NR_BYTES);
    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [1:0] BURST_INCR  = 2'b01;
    localparam logic [1:0] BURST_WRAP  = 2'b10;
    localparam logic [1:0] RESP_OKAY   = 2'b00;

    logic                   clk_i;
    logic                   rst_ni;
    logic [`AXI_ID_W-1:0]   aw_id_i, ar_id_i, b_id_o, r_id_o;
    logic [`AXI_ADDR_W-1:0] aw_addr_i, ar_addr_i;
    logic [7:0]             aw_len_i, ar_len_i;
    logic [2:0]             aw_size_i, ar_size_i;
    logic [1:0]             aw_burst_i, ar_burst_i, b_resp_o, r_resp_o;
    logic                   aw_valid_i, aw_ready_o, ar_valid_i, ar_ready_o;
    logic [`AXI_DATA_W-1:0] w_data_i, r_data_o;
    logic [`AXI_STRB_W-1:0] w_strb_i;
    logic                   w_last_i, w_valid_i, w_ready_o;
    logic                   b_valid_o, b_ready_i;
    logic                   r_last_o, r_valid_o, r_ready_i;

    // reference memory and the beats of the next write burst
    logic [`AXI_DATA_W-1:0] ref_mem [`MEM_WORDS];
    logic [`AXI_DATA_W-1:0] wdata_buf [16];
    logic [`AXI_STRB_W-1:0] wstrb_buf [16];
    logic [31:0]            rng_q;

    tb_clk_gen u_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

    axi_mem_top u_dut (.*);

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_q;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_q = x;
        return x;
    endfunction

    // byte address of a beat by the AXI burst rules
    function automatic logic [`AXI_ADDR_W-1:0] beat_addr(input logic [`AXI_ADDR_W-1:0] start,
            input int len, input logic [1:0] burst, input int beat);
        int win;
        int base;
        win  = (len + 1) * `AXI_STRB_W;
        base = (int'(start) / win) * win;
        case (burst)
            BURST_FIXED: return start;
            BURST_WRAP:  return `AXI_ADDR_W'(base + (int'(start) - base + beat * `AXI_STRB_W) % win);
            default:     return `AXI_ADDR_W'(int'(start) + beat * `AXI_STRB_W);
        endcase
    endfunction

    function automatic int word_of(input logic [`AXI_ADDR_W-1:0] addr);
        return int'(addr) / `AXI_STRB_W;
    endfunction

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            report_fail($sformatf("FAIL at %0t: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic fill_random(input int n);
        for (int i = 0; i < n; i++) begin
            wdata_buf[i] = next_rand();
            wstrb_buf[i] = '1;
        end
    endtask

    // ------------------------------------------------------------
    // AXI master tasks
    // ------------------------------------------------------------
    // W starts w_delay cycles after AW goes valid and b_gaps drops b_ready at random
    task automatic axi_write(input logic [`AXI_ID_W-1:0] id, input logic [`AXI_ADDR_W-1:0] addr,
            input int len, input logic [1:0] burst, input int w_delay, input bit b_gaps);
        int beat;
        int cyc;
        int widx;
        bit aw_done;
        bit hs_aw;
        bit hs_w;
        bit hs_b;
        beat    = 0;
        cyc     = 0;
        aw_done = 1'b0;
        @(posedge clk_i);
        aw_id_i    <= id;
        aw_addr_i  <= addr;
        aw_len_i   <= 8'(len);
        aw_burst_i <= burst;
        while (!aw_done || beat <= len) begin
            if (cyc == TIMEOUT) report_fail("write address or data was never accepted");
            aw_valid_i <= !aw_done;
            w_valid_i  <= (cyc >= w_delay) && (beat <= len);
            if (beat <= len) begin
                w_data_i <= wdata_buf[beat];
                w_strb_i <= wstrb_buf[beat];
                w_last_i <= (beat == len);
            end
            @(negedge clk_i);
            hs_aw = aw_valid_i && aw_ready_o;
            hs_w  = w_valid_i && w_ready_o;
            @(posedge clk_i);
            if (hs_aw) aw_done = 1'b1;
            if (hs_w) begin
                // model takes the strobed bytes of this beat
                widx = word_of(beat_addr(addr, len, burst, beat));
                for (int i = 0; i < `AXI_STRB_W; i++) begin
                    if (wstrb_buf[beat][i]) ref_mem[widx][8*i +: 8] = wdata_buf[beat][8*i +: 8];
                end
                beat++;
            end
            cyc++;
        end
        aw_valid_i <= 1'b0;
        w_valid_i  <= 1'b0;
        w_last_i   <= 1'b0;
        hs_b = 1'b0;
        cyc  = 0;
        while (!hs_b) begin
            if (cyc == TIMEOUT) report_fail("write response never arrived");
            b_ready_i <= !b_gaps || (next_rand() % 4 != 0);
            @(negedge clk_i);
            hs_b = b_valid_o && b_ready_i;
            if (hs_b) begin
                check_eq("b_id_o", b_id_o, id);
                check_eq("b_resp_o", b_resp_o, RESP_OKAY);
            end
            @(posedge clk_i);
            cyc++;
        end
        b_ready_i <= 1'b0;
    endtask

    task automatic axi_read(input logic [`AXI_ID_W-1:0] id, input logic [`AXI_ADDR_W-1:0] addr,
            input int len, input logic [1:0] burst, input bit r_gaps);
        int          beat;
        int          cyc;
        bit          hs_ar;
        bit          stalled;
        logic [31:0] held;
        @(posedge clk_i);
        ar_id_i    <= id;
        ar_addr_i  <= addr;
        ar_len_i   <= 8'(len);
        ar_burst_i <= burst;
        ar_valid_i <= 1'b1;
        hs_ar = 1'b0;
        cyc   = 0;
        while (!hs_ar) begin
            if (cyc == TIMEOUT) report_fail("read address was never accepted");
            @(negedge clk_i);
            hs_ar = ar_ready_o;
            if (hs_ar) check_eq("r_valid_o in AR cycle", r_valid_o, 1'b0);
            @(posedge clk_i);
            cyc++;
        end
        ar_valid_i <= 1'b0;
        beat    = 0;
        cyc     = 0;
        stalled = 1'b0;
        while (beat <= len) begin
            if (cyc == TIMEOUT) report_fail("read data stopped arriving");
            // with gaps on the first beat always waits one cycle
            r_ready_i <= !r_gaps || (cyc != 0 && next_rand() % 4 != 0);
            @(negedge clk_i);
            // first beat exactly one cycle after the AR handshake
            if (cyc == 0) check_eq("r_valid_o after AR", r_valid_o, 1'b1);
            if (stalled) check_eq("r_data_o under stall", r_data_o, held);
            stalled = r_valid_o && !r_ready_i;
            held    = r_data_o;
            if (r_valid_o && r_ready_i) begin
                check_eq("r_data_o", r_data_o, ref_mem[word_of(beat_addr(addr, len, burst, beat))]);
                check_eq("r_last_o", r_last_o, beat == len);
                check_eq("r_id_o", r_id_o, id);
                check_eq("r_resp_o", r_resp_o, RESP_OKAY);
                beat++;
            end
            @(posedge clk_i);
            cyc++;
        end
        r_ready_i <= 1'b0;
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic single_beat_rw();
        fill_random(1);
        axi_write(4'h3, 16'h0040, 0, BURST_INCR, 0, 1'b0);
        axi_read(4'h5, 16'h0040, 0, BURST_INCR, 1'b0);
    endtask

    task automatic incr16_burst();
        fill_random(16);
        axi_write(4'h1, 16'h0100, 15, BURST_INCR, 0, 1'b0);
        axi_read(4'h2, 16'h0100, 15, BURST_INCR, 1'b0);
    endtask

    // starts mid window and wraps from 0x10c back to 0x100
    task automatic wrap4_burst();
        fill_random(4);
        axi_write(4'h6, 16'h0108, 3, BURST_WRAP, 0, 1'b0);
        axi_read(4'h7, 16'h0100, 3, BURST_INCR, 1'b0);
    endtask

    // neighbours at 0x11c and 0x124 still hold the incr16 data
    task automatic fixed4_burst();
        fill_random(4);
        axi_write(4'h8, 16'h0120, 3, BURST_FIXED, 0, 1'b0);
        axi_read(4'h9, 16'h011C, 2, BURST_INCR, 1'b0);
    endtask

    task automatic strobe_merge();
        fill_random(1);
        wstrb_buf[0] = 4'b0101;
        axi_write(4'hA, 16'h0130, 0, BURST_INCR, 0, 1'b0);
        axi_read(4'hB, 16'h0130, 0, BURST_INCR, 1'b0);
    endtask

    task automatic back_pressure();
        fill_random(8);
        axi_write(4'hC, 16'h0200, 7, BURST_INCR, 3, 1'b1);
        axi_read(4'hD, 16'h0200, 7, BURST_INCR, 1'b1);
        axi_read(4'hE, 16'h0208, 7, BURST_WRAP, 1'b1);
    endtask

    initial begin
        int cyc;
        rng_q      = 32'ha03e_d213;
        aw_id_i    = '0;
        aw_addr_i  = '0;
        aw_len_i   = '0;
        aw_size_i  = FULL_SIZE;
        aw_burst_i = BURST_INCR;
        aw_valid_i = 1'b0;
        w_data_i   = '0;
        w_strb_i   = '0;
        w_last_i   = 1'b0;
        w_valid_i  = 1'b0;
        b_ready_i  = 1'b0;
        ar_id_i    = '0;
        ar_addr_i  = '0;
        ar_len_i   = '0;
        ar_size_i  = FULL_SIZE;
        ar_burst_i = BURST_INCR;
        ar_valid_i = 1'b0;
        r_ready_i  = 1'b0;
        cyc        = 0;
        while (rst_ni !== 1'b1) begin
            if (cyc == 10) report_fail("reset was never released");
            @(posedge clk_i);
            cyc++;
        end
        @(negedge clk_i);
        check_eq("ready and valid after reset",
                 {aw_ready_o, ar_ready_o, w_ready_o, r_valid_o, b_valid_o}, '0);
        single_beat_rw();
        incr16_burst();
        wrap4_burst();
        fixed4_burst();
        strobe_merge();
        back_pressure();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/tb_clk_gen.sv
/* testbench clock and reset, 20 ns period, reset held low over three edges */
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o  = 1'b0;
        rst_no = 1'b0;
        // three rising edges see reset low
        repeat (3) @(posedge clk_o);
        rst_no <= 1'b1;
    end

    // half period 10 ns
    always #10 clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- verilog/axi_mem_top.sv
/* AXI4 memory slave top, plain channel ports to the master, adapter and
   SRAM joined by one request interface */
`timescale 1ns/100ps
`default_nettype none
`include "axi_mem_params.svh"

module axi_mem_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // ------------------------------------------------------------
    // write address channel
    // ------------------------------------------------------------
    input  logic [`AXI_ID_W-1:0]   aw_id_i,
    input  logic [`AXI_ADDR_W-1:0] aw_addr_i,
    input  logic [7:0]             aw_len_i,
    input  logic [2:0]             aw_size_i,
    input  logic [1:0]             aw_burst_i,
    input  logic                   aw_valid_i,
    output logic                   aw_ready_o,
    // write data channel
    input  logic [`AXI_DATA_W-1:0] w_data_i,
    input  logic [`AXI_STRB_W-1:0] w_strb_i,
    input  logic                   w_last_i,
    input  logic                   w_valid_i,
    output logic                   w_ready_o,
    // write response channel
    output logic [`AXI_ID_W-1:0]   b_id_o,
    output logic [1:0]             b_resp_o,
    output logic                   b_valid_o,
    input  logic                   b_ready_i,
    // ------------------------------------------------------------
    // read address channel
    // ------------------------------------------------------------
    input  logic [`AXI_ID_W-1:0]   ar_id_i,
    input  logic [`AXI_ADDR_W-1:0] ar_addr_i,
    input  logic [7:0]             ar_len_i,
    input  logic [2:0]             ar_size_i,
    input  logic [1:0]             ar_burst_i,
    input  logic                   ar_valid_i,
    output logic                   ar_ready_o,
    // read data channel
    output logic [`AXI_ID_W-1:0]   r_id_o,
    output logic [`AXI_DATA_W-1:0] r_data_o,
    output logic [1:0]             r_resp_o,
    output logic                   r_last_o,
    output logic                   r_valid_o,
    input  logic                   r_ready_i
);

    // request path between adapter and memory
    mem_req_if u_mem_if ();

    // AXI channel ports share names with the top, so they bind by name
    axi2mem u_axi2mem (
        .mem (u_mem_if.master),
        .*
    );

    sram_bank u_sram (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .mem    (u_mem_if.slave)
    );

endmodule

`default_nettype wire

//--- verilog/sram_bank.sv
/* single-port synchronous SRAM behind mem_req_if, byte enables on writes
   and read data registered one cycle after the request */
`timescale 1ns/100ps
`default_nettype none
`include "axi_mem_params.svh"

module sram_bank (
    input  logic      clk_i,
    input  logic      rst_ni,
    // request port driven by the adapter
    mem_req_if.slave  mem
);

    localparam int ADDR_W = `AXI_ADDR_W;
    localparam int LOG_B  = `LOG_NR_BYTES;
    localparam int IDX_W  = $clog2(`MEM_WORDS);

    logic [`AXI_DATA_W-1:0]  mem_q [`MEM_WORDS];
    // full word address and the part that indexes the array
    logic [ADDR_W-LOG_B-1:0] word_addr;
    logic [IDX_W-1:0]        word_idx;

    assign word_addr = mem.addr[ADDR_W-1:LOG_B];
    assign word_idx  = word_addr[IDX_W-1:0];

    // ------------------------------------------------------------
    // write port
    // ------------------------------------------------------------
    // only the enabled byte lanes change
    always_ff @(posedge clk_i) begin
        if (mem.req && mem.we) begin
            for (int i = 0; i < `AXI_STRB_W; i++) begin
                if (mem.be[i]) begin
                    mem_q[word_idx][8*i +: 8] <= mem.wdata[8*i +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // read port
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            mem.rdata <= '0;
        end else if (mem.req && !mem.we) begin
            mem.rdata <= mem_q[word_idx];
        end
    end

    // upper address bits would otherwise alias onto low words
    idx_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem.req |-> (word_addr < `MEM_WORDS))
        else $error("sram word index out of range");

endmodule

`default_nettype wire

//--- verilog/axi2mem.sv
/* AXI4 slave FSM, one transaction at a time; each burst beat becomes one
   SRAM request, read data and write responses go back on R and B */
`timescale 1ns/100ps
`default_nettype none
`include "axi_mem_params.svh"

module axi2mem import axi_mem_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // write address
    input  logic [`AXI_ID_W-1:0]   aw_id_i,
    input  logic [`AXI_ADDR_W-1:0] aw_addr_i,
    input  logic [7:0]             aw_len_i,
    input  logic [2:0]             aw_size_i,
    input  logic [1:0]             aw_burst_i,
    input  logic                   aw_valid_i,
    output logic                   aw_ready_o,
    // write data
    input  logic [`AXI_DATA_W-1:0] w_data_i,
    input  logic [`AXI_STRB_W-1:0] w_strb_i,
    input  logic                   w_last_i,
    input  logic                   w_valid_i,
    output logic                   w_ready_o,
    // write response
    output logic [`AXI_ID_W-1:0]   b_id_o,
    output logic [1:0]             b_resp_o,
    output logic                   b_valid_o,
    input  logic                   b_ready_i,
    // read address
    input  logic [`AXI_ID_W-1:0]   ar_id_i,
    input  logic [`AXI_ADDR_W-1:0] ar_addr_i,
    input  logic [7:0]             ar_len_i,
    input  logic [2:0]             ar_size_i,
    input  logic [1:0]             ar_burst_i,
    input  logic                   ar_valid_i,
    output logic                   ar_ready_o,
    // read data
    output logic [`AXI_ID_W-1:0]   r_id_o,
    output logic [`AXI_DATA_W-1:0] r_data_o,
    output logic [1:0]             r_resp_o,
    output logic                   r_last_o,
    output logic                   r_valid_o,
    input  logic                   r_ready_i,
    // sram request port
    mem_req_if.master              mem
);

    localparam int         LOG_B     = `LOG_NR_BYTES;
    localparam logic [2:0] FULL_SIZE = 3'(`LOG_NR_BYTES);

    typedef enum logic [2:0] {IDLE, READ, WRITE, WAIT_W, SEND_B} state_t;

    state_t                 state_d, state_q;
    ax_cmd_t                cmd_d, cmd_q;
    logic [`AXI_ADDR_W-1:0] req_addr_d, req_addr_q;
    // beat on R when reading or the next W beat to store when writing
    logic [7:0]             cnt_d, cnt_q;
    logic [7:0]             gen_beat;
    logic [`AXI_ADDR_W-1:0] gen_addr;
    logic                   rd_last;
    logic                   wr_last_exp;

    // ------------------------------------------------------------
    // beat addressing
    // ------------------------------------------------------------
    // reads prefetch one beat ahead of R, writes address the current beat
    assign gen_beat = (state_q == READ) ? cnt_q + 8'd1 : cnt_q;
    assign rd_last  = (cnt_q == cmd_q.len);

    axi_burst_addr_gen u_addr_gen (
        .cmd_i       (cmd_q),
        .beat_i      (gen_beat),
        .next_addr_o (gen_addr)
    );

    // ------------------------------------------------------------
    // FSM and channel outputs
    // ------------------------------------------------------------
    always_comb begin
        state_d    = state_q;
        cmd_d      = cmd_q;
        req_addr_d = req_addr_q;
        cnt_d      = cnt_q;
        // address repeats unless a beat moves on
        mem.req    = 1'b0;
        mem.we     = 1'b0;
        mem.addr   = req_addr_q;
        mem.be     = w_strb_i;
        mem.wdata  = w_data_i;
        // handshakes idle
        aw_ready_o = 1'b0;
        ar_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        b_valid_o  = 1'b0;
        b_id_o     = cmd_q.id;
        b_resp_o   = RESP_OKAY;
        r_valid_o  = 1'b0;
        r_last_o   = 1'b0;
        r_id_o     = cmd_q.id;
        r_data_o   = mem.rdata;
        r_resp_o   = RESP_OKAY;

        case (state_q)
            IDLE: begin
                // read wins when both address channels are valid
                if (ar_valid_i) begin
                    ar_ready_o = 1'b1;
                    cmd_d      = '{id: ar_id_i, addr: ar_addr_i, len: ar_len_i,
                                   size: ar_size_i, burst: axi_burst_t'(ar_burst_i)};
                    // first beat goes to the sram right away
                    mem.req    = 1'b1;
                    mem.addr   = ar_addr_i;
                    req_addr_d = ar_addr_i;
                    cnt_d      = 8'd0;
                    state_d    = READ;
                end else if (aw_valid_i) begin
                    aw_ready_o = 1'b1;
                    w_ready_o  = 1'b1;
                    cmd_d      = '{id: aw_id_i, addr: aw_addr_i, len: aw_len_i,
                                   size: aw_size_i, burst: axi_burst_t'(aw_burst_i)};
                    mem.addr   = aw_addr_i;
                    if (w_valid_i) begin
                        // first beat came along with the address
                        mem.req = 1'b1;
                        mem.we  = 1'b1;
                        cnt_d   = 8'd1;
                        state_d = w_last_i ? SEND_B : WRITE;
                    end else begin
                        cnt_d   = 8'd0;
                        state_d = WAIT_W;
                    end
                end
            end

            // WAIT_W holds beat 0 and WRITE the following ones
            WAIT_W, WRITE: begin
                w_ready_o = 1'b1;
                mem.addr  = gen_addr;
                if (w_valid_i) begin
                    mem.req = 1'b1;
                    mem.we  = 1'b1;
                    cnt_d   = cnt_q + 8'd1;
                    state_d = w_last_i ? SEND_B : WRITE;
                end
            end

            READ: begin
                // keep reading so rdata stays put under back-pressure
                mem.req   = 1'b1;
                r_valid_o = 1'b1;
                r_last_o  = rd_last;
                if (r_ready_i) begin
                    if (rd_last) begin
                        mem.req = 1'b0;
                        state_d = IDLE;
                    end else begin
                        mem.addr   = gen_addr;
                        req_addr_d = gen_addr;
                        cnt_d      = cnt_q + 8'd1;
                    end
                end
            end

            SEND_B: begin
                b_valid_o = 1'b1;
                if (b_ready_i) begin
                    state_d = IDLE;
                end
            end

            default: state_d = IDLE;
        endcase
    end

    // ------------------------------------------------------------
    // registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            cnt_q   <= 8'd0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    // stored command and current sram address
    always_ff @(posedge clk_i) begin
        cmd_q      <= cmd_d;
        req_addr_q <= req_addr_d;
    end

    // ------------------------------------------------------------
    // protocol checks
    // ------------------------------------------------------------
    // master must stick to full width aligned bursts and legal wrap lengths
    aw_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
        aw_valid_i |-> (aw_size_i == FULL_SIZE) && (aw_addr_i[LOG_B-1:0] == '0)
            && ((aw_burst_i != BURST_WRAP) || (aw_len_i inside {8'd1, 8'd3, 8'd7, 8'd15})))
        else $error("unsupported AW request");

    ar_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ar_valid_i |-> (ar_size_i == FULL_SIZE) && (ar_addr_i[LOG_B-1:0] == '0)
            && ((ar_burst_i != BURST_WRAP) || (ar_len_i inside {8'd1, 8'd3, 8'd7, 8'd15})))
        else $error("unsupported AR request");

    // w_last has to line up with the beat count from AW
    assign wr_last_exp = (state_q == IDLE) ? (aw_len_i == 8'd0) : (cnt_q == cmd_q.len);

    w_last_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (w_valid_i && w_ready_o) |-> (w_last_i == wr_last_exp))
        else $error("w_last does not match burst length");

endmodule

`default_nettype wire

//--- verilog/axi_burst_addr_gen.sv
/* combinational beat address for FIXED, INCR and WRAP bursts, fed by the
   adapter with the stored command and the index of the beat it wants */
`timescale 1ns/100ps
`default_nettype none
`include "axi_mem_params.svh"

module axi_burst_addr_gen import axi_mem_pkg::*; (
    input  ax_cmd_t                cmd_i,
    input  logic [7:0]             beat_i,
    output logic [`AXI_ADDR_W-1:0] next_addr_o
);

    localparam int ADDR_W = `AXI_ADDR_W;
    localparam int LOG_B  = `LOG_NR_BYTES;

    logic [ADDR_W-1:0] aligned_addr;
    logic [ADDR_W-1:0] win_bytes;
    logic [ADDR_W-1:0] wrap_boundary;
    logic [ADDR_W-1:0] upper_boundary;
    logic [ADDR_W-1:0] cons_addr;

    // ------------------------------------------------------------
    // window arithmetic
    // ------------------------------------------------------------
    always_comb begin
        // lane bits dropped, transfers are full width
        aligned_addr = {cmd_i.addr[ADDR_W-1:LOG_B], {LOG_B{1'b0}}};

        // wrap window size in bytes, 2/4/8/16 beats
        case (cmd_i.len)
            8'd1:    win_bytes = ADDR_W'(2) << LOG_B;
            8'd3:    win_bytes = ADDR_W'(4) << LOG_B;
            8'd7:    win_bytes = ADDR_W'(8) << LOG_B;
            8'd15:   win_bytes = ADDR_W'(16) << LOG_B;
            // illegal wrap length, degenerate one-word window
            default: win_bytes = ADDR_W'(1) << LOG_B;
        endcase

        // window is aligned to its own size
        wrap_boundary  = aligned_addr & ~(win_bytes - 1'b1);
        upper_boundary = wrap_boundary + win_bytes;

        // plain incrementing address of the requested beat
        cons_addr = aligned_addr + (ADDR_W'(beat_i) << LOG_B);
    end

    // ------------------------------------------------------------
    // burst kind select
    // ------------------------------------------------------------
    always_comb begin
        case (cmd_i.burst)
            // every beat hits the start word
            BURST_FIXED: next_addr_o = aligned_addr;
            BURST_WRAP: begin
                // beat index never exceeds len, so one fold is enough
                if (cons_addr >= upper_boundary) begin
                    next_addr_o = cons_addr - win_bytes;
                end else begin
                    next_addr_o = cons_addr;
                end
            end
            // INCR, and the reserved code treated the same
            default: next_addr_o = cons_addr;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/mem_req_if.sv
/* one request to the single-port SRAM and its read data; the adapter
   drives the request through master, the SRAM answers through slave */
`timescale 1ns/100ps
`default_nettype none
`include "axi_mem_params.svh"

interface mem_req_if ();

    // request strobe, one access per cycle while high
    logic                   req;
    // write enable, low for a read
    logic                   we;
    // byte address, the SRAM drops the lane bits
    logic [`AXI_ADDR_W-1:0] addr;
    // byte enables for writes
    logic [`AXI_STRB_W-1:0] be;
    logic [`AXI_DATA_W-1:0] wdata;
    // read data, valid the cycle after a read request
    logic [`AXI_DATA_W-1:0] rdata;

    // request side
    modport master (
        output req, we, addr, be, wdata,
        input  rdata
    );

    // memory side
    modport slave (
        input  req, we, addr, be, wdata,
        output rdata
    );

endinterface

`default_nettype wire

//--- verilog/axi_mem_pkg.sv
/* burst, response and stored command types of the AXI memory slave,
   imported by the RTL modules */
`default_nettype none
`include "axi_mem_params.svh"

package axi_mem_pkg;

    // ------------------------------------------------------------
    // AXI encodings
    // ------------------------------------------------------------
    // burst kind, 2'b11 is reserved by the protocol
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_t;

    // response codes, the slave only ever answers OKAY
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_t;

    // ------------------------------------------------------------
    // command captured on the AW or AR handshake
    // ------------------------------------------------------------
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        // start address of the burst
        logic [`AXI_ADDR_W-1:0] addr;
        // beats minus one
        logic [7:0]             len;
        // log2 of bytes per beat
        logic [2:0]             size;
        axi_burst_t             burst;
    } ax_cmd_t;

endpackage

`default_nettype wire

//--- verilog/axi_mem_params.svh
/* widths and memory depth shared by the AXI memory slave and its testbench,
   pulled in with an include wherever a width is needed */
`ifndef AXI_MEM_PARAMS_SVH
`define AXI_MEM_PARAMS_SVH

// ------------------------------------------------------------
// AXI channel widths
// ------------------------------------------------------------
// transaction id
`define AXI_ID_W 4
// byte address
`define AXI_ADDR_W 16
// data bus, full width transfers only
`define AXI_DATA_W 32

// derived byte lane count and its log2
`define AXI_STRB_W (`AXI_DATA_W / 8)
`define LOG_NR_BYTES ($clog2(`AXI_STRB_W))

// ------------------------------------------------------------
// memory
// ------------------------------------------------------------
// sram depth in data words
`define MEM_WORDS 1024

`endif
